// ==== hw/kvs_pkg.sv ====
package kvs_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // stream word format
   ////////////////////////////////////////////////////////////////////////////

   localparam int DATA_WIDTH = 64;
   localparam int KEEP_WIDTH = 8;

   // lane fan-out
   localparam int NUM_LANES      = 4;
   localparam int LANE_IDX_WIDTH = 2;
   localparam int LANE_DEPTH     = 8;

   // statistics taps
   localparam int CNT_WIDTH = 32;

   ////////////////////////////////////////////////////////////////////////////
   // host register map
   ////////////////////////////////////////////////////////////////////////////

   localparam int APB_ADDR_WIDTH = 8;
   localparam int APB_DATA_WIDTH = 32;

   localparam int REG_CLEAR_ADDR   = 'h00;
   // lane n packet count at base + n*stride, word count 4 above it
   localparam int REG_STATS_BASE   = 'h10;
   localparam int REG_LANE_STRIDE  = 8;
   localparam int REG_WORDS_OFFSET = 4;

endpackage

// ==== hw/pkt_stream_if.sv ====
`timescale 1ns/1ps

interface pkt_stream_if;
   import kvs_pkg::*;

   // one word of a packet, last marks the final word
   logic [DATA_WIDTH-1:0] data;
   logic [KEEP_WIDTH-1:0] keep;
   logic                  last;

   // handshake, transfer when both are high at the clock edge
   logic                  valid;
   logic                  ready;

   modport source (
      output data,
      output keep,
      output last,
      output valid,
      input  ready
   );

   modport sink (
      input  data,
      input  keep,
      input  last,
      input  valid,
      output ready
   );

endinterface

// ==== hw/pkt_dispatch.sv ====
`timescale 1ns/1ps

module pkt_dispatch (
   input  logic                          axi_clk,
   input  logic                          rst,
   input  logic [kvs_pkg::DATA_WIDTH-1:0] in_data,
   input  logic [kvs_pkg::KEEP_WIDTH-1:0] in_keep,
   input  logic                          in_last,
   input  logic                          in_valid,
   output logic                          in_ready,
   pkt_stream_if.source                  lanes [kvs_pkg::NUM_LANES]
);
   import kvs_pkg::*;

   logic [LANE_IDX_WIDTH-1:0] lane_ptr;
   logic [NUM_LANES-1:0]      lane_ready;
   logic                      last_accepted;

   ////////////////////////////////////////////////////////////////////////////
   // steering
   ////////////////////////////////////////////////////////////////////////////

   // payload goes to every lane, only the selected one sees valid
   for (genvar g = 0; g < NUM_LANES; g++) begin : g_steer
      assign lanes[g].data  = in_data;
      assign lanes[g].keep  = in_keep;
      assign lanes[g].last  = in_last;
      assign lanes[g].valid = in_valid && (lane_ptr == LANE_IDX_WIDTH'(g));
      assign lane_ready[g]  = lanes[g].ready;
   end

   assign in_ready = lane_ready[lane_ptr];

   assign last_accepted = in_valid && in_ready && in_last;

   ////////////////////////////////////////////////////////////////////////////
   // round-robin pointer
   ////////////////////////////////////////////////////////////////////////////

   // move on only at a packet boundary so packets never split
   always_ff @(posedge axi_clk) begin
      if (rst) begin
         lane_ptr <= '0;
      end else if (last_accepted) begin
         if (lane_ptr == LANE_IDX_WIDTH'(NUM_LANES - 1)) begin
            lane_ptr <= '0;
         end else begin
            lane_ptr <= lane_ptr + 1'b1;
         end
      end
   end

endmodule

// ==== hw/pkt_lane.sv ====
`timescale 1ns/1ps

module pkt_lane (
   input  logic                          axi_clk,
   input  logic                          rst,
   pkt_stream_if.sink                    in,
   pkt_stream_if.source                  out,
   input  logic                          clear,
   output logic [kvs_pkg::CNT_WIDTH-1:0] pkt_count,
   output logic [kvs_pkg::CNT_WIDTH-1:0] word_count
);
   import kvs_pkg::*;

   // word storage, data keep and last side by side
   logic [DATA_WIDTH-1:0] mem_data [LANE_DEPTH];
   logic [KEEP_WIDTH-1:0] mem_keep [LANE_DEPTH];
   logic                  mem_last [LANE_DEPTH];

   logic [$clog2(LANE_DEPTH)-1:0] wr_ptr;
   logic [$clog2(LANE_DEPTH)-1:0] rd_ptr;
   logic [$clog2(LANE_DEPTH):0]   fill;

   logic push;
   logic pop;

   ////////////////////////////////////////////////////////////////////////////
   // handshake
   ////////////////////////////////////////////////////////////////////////////

   assign in.ready  = (fill != ($clog2(LANE_DEPTH) + 1)'(LANE_DEPTH));
   assign out.valid = (fill != '0);

   assign push = in.valid && in.ready;
   assign pop  = out.valid && out.ready;

   assign out.data = mem_data[rd_ptr];
   assign out.keep = mem_keep[rd_ptr];
   assign out.last = mem_last[rd_ptr];

   ////////////////////////////////////////////////////////////////////////////
   // circular buffer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge axi_clk) begin
      if (push) begin
         mem_data[wr_ptr] <= in.data;
         mem_keep[wr_ptr] <= in.keep;
         mem_last[wr_ptr] <= in.last;
      end
   end

   // depth is a power of two, pointers wrap on their own
   always_ff @(posedge axi_clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   // statistics tap, clear beats a same-cycle word
   always_ff @(posedge axi_clk) begin
      if (rst || clear) begin
         pkt_count  <= '0;
         word_count <= '0;
      end else if (push) begin
         word_count <= word_count + 1'b1;
         if (in.last) begin
            pkt_count <= pkt_count + 1'b1;
         end
      end
   end

endmodule

// ==== hw/pkt_collect.sv ====
`timescale 1ns/1ps

module pkt_collect (
   input  logic                           axi_clk,
   input  logic                           rst,
   pkt_stream_if.sink                     lanes [kvs_pkg::NUM_LANES],
   output logic [kvs_pkg::DATA_WIDTH-1:0] out_data,
   output logic [kvs_pkg::KEEP_WIDTH-1:0] out_keep,
   output logic                           out_last,
   output logic                           out_valid,
   input  logic                           out_ready
);
   import kvs_pkg::*;

   logic [LANE_IDX_WIDTH-1:0] lane_ptr;

   // lane outputs gathered into plain arrays for the mux
   logic [DATA_WIDTH-1:0] lane_data [NUM_LANES];
   logic [KEEP_WIDTH-1:0] lane_keep [NUM_LANES];
   logic [NUM_LANES-1:0]  lane_last;
   logic [NUM_LANES-1:0]  lane_valid;

   for (genvar g = 0; g < NUM_LANES; g++) begin : g_gather
      assign lane_data[g]   = lanes[g].data;
      assign lane_keep[g]   = lanes[g].keep;
      assign lane_last[g]   = lanes[g].last;
      assign lane_valid[g]  = lanes[g].valid;
      // only the lane being drained sees out_ready
      assign lanes[g].ready = out_ready && (lane_ptr == LANE_IDX_WIDTH'(g));
   end

   ////////////////////////////////////////////////////////////////////////////
   // output mux
   ////////////////////////////////////////////////////////////////////////////

   assign out_data  = lane_data[lane_ptr];
   assign out_keep  = lane_keep[lane_ptr];
   assign out_last  = lane_last[lane_ptr];
   assign out_valid = lane_valid[lane_ptr];

   // follows the dispatcher order, one packet per lane
   always_ff @(posedge axi_clk) begin
      if (rst) begin
         lane_ptr <= '0;
      end else if (out_valid && out_ready && out_last) begin
         if (lane_ptr == LANE_IDX_WIDTH'(NUM_LANES - 1)) begin
            lane_ptr <= '0;
         end else begin
            lane_ptr <= lane_ptr + 1'b1;
         end
      end
   end

endmodule

// ==== hw/stats_regs.sv ====
`timescale 1ns/1ps

module stats_regs (
   input  logic                                                axi_clk,
   input  logic                                                rst,
   input  logic                                                psel,
   input  logic                                                penable,
   input  logic                                                pwrite,
   input  logic [kvs_pkg::APB_ADDR_WIDTH-1:0]                  paddr,
   input  logic [kvs_pkg::APB_DATA_WIDTH-1:0]                  pwdata,
   output logic [kvs_pkg::APB_DATA_WIDTH-1:0]                  prdata,
   input  logic [kvs_pkg::NUM_LANES-1:0][kvs_pkg::CNT_WIDTH-1:0] pkt_counts,
   input  logic [kvs_pkg::NUM_LANES-1:0][kvs_pkg::CNT_WIDTH-1:0] word_counts,
   output logic [kvs_pkg::NUM_LANES-1:0]                       clear
);
   import kvs_pkg::*;

   logic wr_access;
   logic rd_select;

   // zero wait states, writes land in the access phase
   assign wr_access = psel && penable && pwrite;
   assign rd_select = psel && !pwrite;

   ////////////////////////////////////////////////////////////////////////////
   // clear register
   ////////////////////////////////////////////////////////////////////////////

   // one-cycle pulse per masked lane, low again on the next edge
   always_ff @(posedge axi_clk) begin
      if (rst) begin
         clear <= '0;
      end else if (wr_access && (paddr == APB_ADDR_WIDTH'(REG_CLEAR_ADDR))) begin
         clear <= pwdata[NUM_LANES-1:0];
      end else begin
         clear <= '0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read mux
   ////////////////////////////////////////////////////////////////////////////

   // clear register and holes read back as zero
   always_comb begin
      prdata = '0;
      if (rd_select) begin
         for (int i = 0; i < NUM_LANES; i++) begin
            if (paddr == APB_ADDR_WIDTH'(REG_STATS_BASE + i * REG_LANE_STRIDE)) begin
               prdata = pkt_counts[i];
            end
            if (paddr == APB_ADDR_WIDTH'(REG_STATS_BASE + i * REG_LANE_STRIDE
                                         + REG_WORDS_OFFSET)) begin
               prdata = word_counts[i];
            end
         end
      end
   end

endmodule

// ==== hw/kvs_stream_top.sv ====
`timescale 1ns/1ps

module kvs_stream_top (
   input  logic                              axi_clk,
   input  logic                              rst,
   // packet input
   input  logic [kvs_pkg::DATA_WIDTH-1:0]     in_data,
   input  logic [kvs_pkg::KEEP_WIDTH-1:0]     in_keep,
   input  logic                              in_last,
   input  logic                              in_valid,
   output logic                              in_ready,
   // packet output
   output logic [kvs_pkg::DATA_WIDTH-1:0]     out_data,
   output logic [kvs_pkg::KEEP_WIDTH-1:0]     out_keep,
   output logic                              out_last,
   output logic                              out_valid,
   input  logic                              out_ready,
   // host access to the counters
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [kvs_pkg::APB_ADDR_WIDTH-1:0] paddr,
   input  logic [kvs_pkg::APB_DATA_WIDTH-1:0] pwdata,
   output logic [kvs_pkg::APB_DATA_WIDTH-1:0] prdata
);
   import kvs_pkg::*;

   pkt_stream_if lane_in  [NUM_LANES] ();
   pkt_stream_if lane_out [NUM_LANES] ();

   logic [NUM_LANES-1:0][CNT_WIDTH-1:0] pkt_counts;
   logic [NUM_LANES-1:0][CNT_WIDTH-1:0] word_counts;
   logic [NUM_LANES-1:0]                clear;

   ////////////////////////////////////////////////////////////////////////////
   // stream path
   ////////////////////////////////////////////////////////////////////////////

   pkt_dispatch dispatch_i (
      .axi_clk  (axi_clk),
      .rst      (rst),
      .in_data  (in_data),
      .in_keep  (in_keep),
      .in_last  (in_last),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .lanes    (lane_in)
   );

   for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
      pkt_lane lane_i (
         .axi_clk    (axi_clk),
         .rst        (rst),
         .in         (lane_in[g]),
         .out        (lane_out[g]),
         .clear      (clear[g]),
         .pkt_count  (pkt_counts[g]),
         .word_count (word_counts[g])
      );
   end

   pkt_collect collect_i (
      .axi_clk   (axi_clk),
      .rst       (rst),
      .lanes     (lane_out),
      .out_data  (out_data),
      .out_keep  (out_keep),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   // counter readout and clear
   stats_regs regs_i (
      .axi_clk     (axi_clk),
      .rst         (rst),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pkt_counts  (pkt_counts),
      .word_counts (word_counts),
      .clear       (clear)
   );

endmodule

// ==== verif/tb_kvs_stream.sv ====
`timescale 1ns/1ps

module tb_kvs_stream;
   import kvs_pkg::*;

   localparam logic [31:0] SEED           = 32'h64a6_5d0d;
   localparam int          NUM_PKTS       = 40;
   localparam int          NUM_PKTS_AFTER = 12;
   localparam int          TIMEOUT_CYCLES = (NUM_PKTS + NUM_PKTS_AFTER) * 40;

   logic                      axi_clk = 1'b0;
   logic                      rst;
   logic [DATA_WIDTH-1:0]     in_data;
   logic [KEEP_WIDTH-1:0]     in_keep;
   logic                      in_last;
   logic                      in_valid;
   logic                      in_ready;
   logic [DATA_WIDTH-1:0]     out_data;
   logic [KEEP_WIDTH-1:0]     out_keep;
   logic                      out_last;
   logic                      out_valid;
   logic                      out_ready;
   logic                      psel;
   logic                      penable;
   logic                      pwrite;
   logic [APB_ADDR_WIDTH-1:0] paddr;
   logic [APB_DATA_WIDTH-1:0] pwdata;
   logic [APB_DATA_WIDTH-1:0] prdata;

   // reference model of the expected words as {last, keep, data}
   logic [72:0] exp_q [$];
   logic [31:0] exp_pkts  [NUM_LANES];
   logic [31:0] exp_words [NUM_LANES];
   logic [31:0] tx_state = SEED;
   logic [31:0] rx_state = ~SEED;
   int          pkt_idx = 0;
   int          errors = 0;
   int          words_checked = 0;
   logic        tx_done;

   kvs_stream_top dut_i (
      .axi_clk (axi_clk), .rst (rst),
      .in_data (in_data), .in_keep (in_keep), .in_last (in_last),
      .in_valid (in_valid), .in_ready (in_ready),
      .out_data (out_data), .out_keep (out_keep), .out_last (out_last),
      .out_valid (out_valid), .out_ready (out_ready),
      .psel (psel), .penable (penable), .pwrite (pwrite),
      .paddr (paddr), .pwdata (pwdata), .prdata (prdata)
   );

   always #2 axi_clk = ~axi_clk;

   // run limit scales with the number of packets
   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge axi_clk);
      $display("Timeout: traffic did not drain within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
   end

   function automatic logic [31:0] next_rand(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // APB accesses started on a falling edge
   ////////////////////////////////////////////////////////////////////////////

   task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
      psel = 1'b1;
      pwrite = 1'b0;
      paddr = addr;
      @(negedge axi_clk);
      penable = 1'b1;
      #1;
      data = prdata;
      @(negedge axi_clk);
      psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      psel = 1'b1;
      pwrite = 1'b1;
      paddr = addr;
      pwdata = data;
      @(negedge axi_clk);
      penable = 1'b1;
      @(negedge axi_clk);
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      // clear pulse lands on the following edge
      @(negedge axi_clk);
   endtask

   task automatic check_counters();
      logic [31:0] v;
      for (int n = 0; n < NUM_LANES; n++) begin
         read_reg(8'(REG_STATS_BASE + n * REG_LANE_STRIDE), v);
         check_value($sformatf("pkt_count[%0d]", n), 64'(v), 64'(exp_pkts[n]));
         read_reg(8'(REG_STATS_BASE + n * REG_LANE_STRIDE + REG_WORDS_OFFSET), v);
         check_value($sformatf("word_count[%0d]", n), 64'(v), 64'(exp_words[n]));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stream traffic
   ////////////////////////////////////////////////////////////////////////////

   task automatic send_packets(input int count);
      int          len;
      int          lane;
      logic        accepted;
      logic [63:0] d;
      logic [7:0]  k;
      for (int p = 0; p < count; p++) begin
         tx_state = next_rand(tx_state);
         len = 1 + int'(tx_state[31:16] % 12);
         // packet k lands in lane k mod 4
         lane = pkt_idx % NUM_LANES;
         pkt_idx++;
         exp_pkts[lane] = exp_pkts[lane] + 32'd1;
         exp_words[lane] = exp_words[lane] + 32'(len);
         for (int w = 0; w < len; w++) begin
            tx_state = next_rand(tx_state);
            while (tx_state[29:28] == 2'b00) begin
               @(negedge axi_clk);
               tx_state = next_rand(tx_state);
            end
            d[63:32] = tx_state;
            tx_state = next_rand(tx_state);
            d[31:0] = tx_state;
            k = (w == len - 1) ? (tx_state[23:16] | 8'h01) : 8'hff;
            exp_q.push_back({w == len - 1, k, d});
            in_valid = 1'b1;
            in_data = d;
            in_keep = k;
            in_last = (w == len - 1);
            accepted = 1'b0;
            while (!accepted) begin
               #1;
               accepted = in_ready;
               @(negedge axi_clk);
            end
            in_valid = 1'b0;
         end
      end
      tx_done = 1'b1;
   endtask

   task automatic drain_output();
      logic [72:0] w;
      while (!(tx_done && exp_q.size() == 0)) begin
         @(negedge axi_clk);
         rx_state = next_rand(rx_state);
         out_ready = (rx_state[31:30] != 2'b00);
         #1;
         if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
               $display("Output word appeared with no word left to expect");
               errors++;
            end else begin
               w = exp_q.pop_front();
               check_value("out_data", out_data, w[63:0]);
               check_value("out_keep", 64'(out_keep), 64'(w[71:64]));
               check_value("out_last", 64'(out_last), 64'(w[72]));
               words_checked++;
            end
         end
      end
      @(negedge axi_clk);
      #1;
      check_value("out_valid after drain", 64'(out_valid), 64'd0);
      @(negedge axi_clk);
   endtask

   task automatic run_traffic(input int count);
      tx_done = 1'b0;
      fork
         send_packets(count);
         drain_output();
      join
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      logic [31:0] rd;
      logic [3:0]  mask;
      logic [7:0]  holes [5];
      holes = '{8'(REG_CLEAR_ADDR), 8'h04, 8'h0c, 8'h30, 8'hfc};
      rst = 1'b1;
      in_data = '0;
      in_keep = '0;
      in_last = 1'b0;
      in_valid = 1'b0;
      out_ready = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      for (int n = 0; n < NUM_LANES; n++) begin
         exp_pkts[n] = '0;
         exp_words[n] = '0;
      end
      repeat (3) @(posedge axi_clk);
      @(negedge axi_clk);
      rst = 1'b0;
      #1;
      check_value("out_valid", 64'(out_valid), 64'd0);
      check_value("in_ready", 64'(in_ready), 64'd1);
      @(negedge axi_clk);
      check_counters();

      run_traffic(NUM_PKTS);
      check_counters();

      // clear register and holes with live counters behind them
      foreach (holes[i]) begin
         read_reg(holes[i], rd);
         check_value($sformatf("prdata at %h", holes[i]), 64'(rd), 64'd0);
      end

      tx_state = next_rand(tx_state);
      mask = tx_state[27:24];
      if (mask == 4'h0 || mask == 4'hf) begin
         mask = 4'b0110;
      end
      write_reg(8'(REG_CLEAR_ADDR), 32'(mask));
      for (int n = 0; n < NUM_LANES; n++) begin
         if (mask[n]) begin
            exp_pkts[n] = '0;
            exp_words[n] = '0;
         end
      end
      check_counters();

      run_traffic(NUM_PKTS_AFTER);
      check_counters();

      $display("%0d errors, %0d words checked", errors, words_checked);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
hw/kvs_pkg.sv
hw/pkt_stream_if.sv
hw/pkt_dispatch.sv
hw/pkt_lane.sv
hw/pkt_collect.sv
hw/stats_regs.sv
hw/kvs_stream_top.sv
verif/tb_kvs_stream.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
   -f sources.f --top-module tb_kvs_stream \
   -Mdir obj_dir -o sim_kvs_stream
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/sim_kvs_stream)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# pass only if the testbench reported a clean run
if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1
